// File: Makefile
TOP := exec_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null

clean:
	rm -rf obj_dir

// File: build.f
common/ooo_pkg.sv
reorder_buffer/reorder_buffer.sv
source/rename_regfile.sv
source/reservation_station.sv
source/alu.sv
source/multiplier.sv
source/cdb_arbiter.sv
source/exec_core_top.sv
sim/exec_core_tb.sv

// File: common/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  localparam int NUM_REGS  = 8;
  localparam int ROB_DEPTH = 8;

  typedef logic [31:0]                  word_t;     // operands, results, immediates
  typedef logic [$clog2(NUM_REGS)-1:0]  reg_addr_t; // architectural register number
  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;  // reorder buffer index
  typedef logic [2:0]                   alu_func_t;

  localparam alu_func_t ALU_ADD = 3'd0;
  localparam alu_func_t ALU_SUB = 3'd1;
  localparam alu_func_t ALU_AND = 3'd2;
  localparam alu_func_t ALU_OR  = 3'd3;
  localparam alu_func_t ALU_XOR = 3'd4;
  localparam alu_func_t ALU_SLL = 3'd5; // shift amount from op2[4:0]
  localparam alu_func_t ALU_SRL = 3'd6; // logical shift
  localparam alu_func_t ALU_SLT = 3'd7; // signed compare, 1 or 0

endpackage

`default_nettype wire

// File: reorder_buffer/reorder_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer import ooo_pkg::*; (
  input  wire            clk_100mhz,
  input  wire            sys_rst,
  input  wire            i_alloc,
  input  wire reg_addr_t i_alloc_rd,
  input  wire            i_cdb_valid,
  input  wire rob_tag_t  i_cdb_tag,
  input  wire word_t     i_cdb_value,
  input  wire rob_tag_t  i_rd_tag1,
  input  wire rob_tag_t  i_rd_tag2,
  output rob_tag_t       o_alloc_tag,
  output logic           o_full,
  output logic           o_rd_done1,
  output word_t          o_rd_val1,
  output logic           o_rd_done2,
  output word_t          o_rd_val2,
  output logic           o_commit_valid,
  output reg_addr_t      o_commit_rd,
  output word_t          o_commit_value,
  output rob_tag_t       o_commit_tag
);

  reg_addr_t            entry_rd  [ROB_DEPTH];
  word_t                entry_val [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] entry_done;

  rob_tag_t                       head;
  rob_tag_t                       tail;
  logic [$clog2(ROB_DEPTH+1)-1:0] count;
  logic                           commit_go;

  assign o_alloc_tag = tail; // new tag is always the tail slot
  assign o_full      = (count == ROB_DEPTH);
  assign commit_go   = (count != 0) && entry_done[head]; // done flag of a freed slot is stale

  // operand reads at issue
  assign o_rd_done1 = entry_done[i_rd_tag1];
  assign o_rd_val1  = entry_val[i_rd_tag1];
  assign o_rd_done2 = entry_done[i_rd_tag2];
  assign o_rd_val2  = entry_val[i_rd_tag2];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head           <= '0;
      tail           <= '0;
      count          <= '0;
      entry_done     <= '0;
      o_commit_valid <= 1'b0;
    end else begin
      o_commit_valid <= commit_go; // one pulse per retired entry
      if (i_cdb_valid) begin
        entry_done[i_cdb_tag] <= 1'b1;
      end
      if (i_alloc) begin
        entry_done[tail] <= 1'b0;
        tail             <= tail + 1'b1;
      end
      if (commit_go) begin
        head <= head + 1'b1;
      end
      case ({i_alloc, commit_go})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_alloc) begin
      entry_rd[tail] <= i_alloc_rd;
    end
    if (i_cdb_valid) begin
      entry_val[i_cdb_tag] <= i_cdb_value;
    end
    if (commit_go) begin
      o_commit_rd    <= entry_rd[head];
      o_commit_value <= entry_val[head];
      o_commit_tag   <= head;
    end
  end

endmodule

`default_nettype wire

// File: sim/exec_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module exec_core_tb import ooo_pkg::*; ();

  localparam int MUL_STAGES   = 6; // deep enough that a mul chain fills the rob
  localparam int NUM_INSTR    = 400;
  localparam int CLK_PERIOD   = 10;
  localparam int WORST_CYCLES = 2 * MUL_STAGES + 20;

  logic      clk_100mhz;
  logic      sys_rst;
  logic      i_issue_valid;
  logic      i_issue_is_mul;
  alu_func_t i_issue_func;
  reg_addr_t i_issue_rs1;
  reg_addr_t i_issue_rs2;
  logic      i_issue_use_imm;
  word_t     i_issue_imm;
  reg_addr_t i_issue_rd;
  logic      o_issue_ready;
  logic      o_commit_valid;
  reg_addr_t o_commit_rd;
  word_t     o_commit_value;
  rob_tag_t  o_commit_tag;

  logic [31:0] lfsr_state = 32'h621c_85bf;
  string       cur_name   = "reset";
  reg_addr_t   last_rd;

  // in-order reference model and expected commit stream
  word_t     model_regs [NUM_REGS] = '{default: '0};
  reg_addr_t exp_rd_q   [$];
  word_t     exp_val_q  [$];
  rob_tag_t  exp_tag_q  [$];
  logic      exp_mul_q  [$];
  string     exp_name_q [$];
  rob_tag_t  next_tag    = '0;
  int        n_accepted  = 0;
  int        n_committed = 0;
  int        out_mul     = 0; // uncommitted multiplies
  int        out_alu     = 0;
  int        full_seen   = 0;

  exec_core_top #(
    .MUL_STAGES(MUL_STAGES)
  ) u_exec_core_top (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_issue_valid(i_issue_valid), .i_issue_is_mul(i_issue_is_mul),
    .i_issue_func(i_issue_func), .i_issue_rs1(i_issue_rs1), .i_issue_rs2(i_issue_rs2),
    .i_issue_use_imm(i_issue_use_imm), .i_issue_imm(i_issue_imm), .i_issue_rd(i_issue_rd),
    .o_issue_ready(o_issue_ready), .o_commit_valid(o_commit_valid),
    .o_commit_rd(o_commit_rd), .o_commit_value(o_commit_value), .o_commit_tag(o_commit_tag)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #(CLK_PERIOD / 2) clk_100mhz = ~clk_100mhz;
  end

  // galois lfsr over x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] take_bits(input int width);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < width; i++) begin
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic word_t expected_result(input logic is_mul, input alu_func_t func,
                                            input word_t a, input word_t b);
    word_t r;
    if (is_mul) begin
      r = a * b; // low half of the product
    end else begin
      case (func)
        ALU_ADD: r = a + b;
        ALU_SUB: r = a - b;
        ALU_AND: r = a & b;
        ALU_OR:  r = a | b;
        ALU_XOR: r = a ^ b;
        ALU_SLL: r = a << b[4:0];
        ALU_SRL: r = a >> b[4:0];
        default: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      endcase
    end
    return r;
  endfunction

  task automatic end_in_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %0h actual %0h", name, expected, actual);
      end_in_failure();
    end
  endtask

  task automatic set_instr(input int n);
    i_issue_is_mul  = 1'b0;
    i_issue_func    = alu_func_t'(take_bits(3));
    i_issue_rs1     = reg_addr_t'(take_bits(3));
    i_issue_rs2     = reg_addr_t'(take_bits(3));
    i_issue_use_imm = 1'(take_bits(1));
    i_issue_imm     = take_bits(32);
    i_issue_rd      = reg_addr_t'(take_bits(3));
    if (n < 8) begin
      cur_name        = "register load"; // each register ors an immediate into itself
      i_issue_func    = ALU_OR;
      i_issue_rs1     = reg_addr_t'(n);
      i_issue_rd      = reg_addr_t'(n);
      i_issue_use_imm = 1'b1;
    end else if (n < 80) begin
      cur_name     = "independent alu";
      i_issue_func = alu_func_t'(n % 8); // walk all eight functions
      i_issue_rs1  = {1'b0, i_issue_rs1[1:0]};
      i_issue_rs2  = {1'b0, i_issue_rs2[1:0]};
      i_issue_rd   = {1'b1, i_issue_rd[1:0]};
    end else if (n < 160) begin
      cur_name    = "dependent chain";
      i_issue_rs1 = last_rd;
    end else if (n < 260) begin
      cur_name       = "mixed multiply";
      i_issue_is_mul = (take_bits(3) < 3);
    end else if (n < 280) begin
      cur_name       = "register rewrite"; // r1 rewritten with reads of it in between
      i_issue_rs1    = 3'd1;
      i_issue_rd     = (n % 2 == 0) ? 3'd1 : 3'd2;
      i_issue_is_mul = 1'(take_bits(1));
    end else begin
      cur_name = "rob fill";
      if ((n - 280) % 12 < 2) begin
        i_issue_is_mul  = 1'b1; // two chained muls hold the rob head
        i_issue_rs1     = 3'd7;
        i_issue_rs2     = 3'd6;
        i_issue_rd      = 3'd7;
        i_issue_use_imm = 1'b0;
      end else begin
        i_issue_rs1     = 3'd6;
        i_issue_use_imm = 1'b1;
        i_issue_rd      = reg_addr_t'(take_bits(3) % 6);
      end
    end
    last_rd = i_issue_rd;
  endtask

  task automatic check_commit();
    string name;
    if (exp_val_q.size() == 0) begin
      $display("commit of register %0d seen with no instruction outstanding", o_commit_rd);
      end_in_failure();
    end else begin
      name = exp_name_q.pop_front();
      compare_value({name, " commit rd"}, 32'(exp_rd_q.pop_front()), 32'(o_commit_rd));
      compare_value({name, " commit tag"}, 32'(exp_tag_q.pop_front()), 32'(o_commit_tag));
      compare_value({name, " commit value"}, exp_val_q.pop_front(), o_commit_value);
      if (exp_mul_q.pop_front()) begin
        out_mul--;
      end else begin
        out_alu--;
      end
      n_committed++;
    end
  endtask

  task automatic check_issue();
    int    outstanding;
    int    same_kind;
    word_t a;
    word_t b;
    word_t result;
    outstanding = n_accepted - n_committed; // equals the rob count here
    same_kind   = i_issue_is_mul ? out_mul : out_alu;
    if (outstanding >= ROB_DEPTH) begin
      full_seen++;
      compare_value({cur_name, " issue ready with full rob"}, 32'd0, 32'(o_issue_ready));
    end else if (!o_issue_ready && (same_kind == 0)) begin
      $display("issue ready dropped with %0d outstanding and the selected station empty",
               outstanding);
      end_in_failure();
    end else if (o_issue_ready) begin
      a      = model_regs[i_issue_rs1];
      b      = i_issue_use_imm ? i_issue_imm : model_regs[i_issue_rs2];
      result = expected_result(i_issue_is_mul, i_issue_func, a, b);
      model_regs[i_issue_rd] = result;
      exp_rd_q.push_back(i_issue_rd);
      exp_val_q.push_back(result);
      exp_tag_q.push_back(next_tag);
      exp_mul_q.push_back(i_issue_is_mul);
      exp_name_q.push_back(cur_name);
      next_tag = next_tag + 1'b1; // tags count up modulo 8
      if (i_issue_is_mul) begin
        out_mul++;
      end else begin
        out_alu++;
      end
      n_accepted++;
    end
  endtask

  // outputs settle long before the falling edge
  always @(negedge clk_100mhz) begin
    if (!sys_rst) begin
      if (o_commit_valid) begin
        check_commit();
      end
      if (i_issue_valid) begin
        check_issue();
      end
    end
  end

  initial begin
    sys_rst         = 1'b1;
    i_issue_valid   = 1'b0;
    i_issue_is_mul  = 1'b0;
    i_issue_func    = ALU_ADD;
    i_issue_rs1     = '0;
    i_issue_rs2     = '0;
    i_issue_use_imm = 1'b0;
    i_issue_imm     = '0;
    i_issue_rd      = '0;
    last_rd         = '0;
    repeat (3) @(posedge clk_100mhz);
    #1;
    sys_rst = 1'b0;
    for (int n = 0; n < NUM_INSTR; n++) begin
      set_instr(n);
      i_issue_valid = 1'b1;
      while (n_accepted == n) @(posedge clk_100mhz); // held until accepted
      #1;
    end
    i_issue_valid = 1'b0;
    wait (n_committed == NUM_INSTR);
    repeat (2 * WORST_CYCLES) @(posedge clk_100mhz); // catch stray commits
    if (full_seen == 0) begin
      $display("the reorder buffer never filled, so issue back-pressure was not exercised");
      end_in_failure();
    end else if ((n_committed == n_accepted) && (exp_val_q.size() == 0)) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("%0d issues accepted but %0d commits seen", n_accepted, n_committed);
      end_in_failure();
    end
  end

  initial begin
    #((NUM_INSTR * WORST_CYCLES + 100) * CLK_PERIOD);
    $display("timeout with %0d of %0d instructions committed, the core appears to hang",
             n_committed, NUM_INSTR);
    end_in_failure();
  end

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import ooo_pkg::*; (
  input  wire            clk_100mhz,
  input  wire            sys_rst,
  input  wire            i_valid,
  input  wire alu_func_t i_func,
  input  wire rob_tag_t  i_tag,
  input  wire word_t     i_op1,
  input  wire word_t     i_op2,
  input  wire            i_grant,
  output logic           o_ready,
  output logic           o_done,
  output rob_tag_t       o_tag,
  output word_t          o_result
);

  word_t alu_out;

  assign o_ready = !o_done || i_grant; // output reg empty or draining

  always_comb begin
    case (i_func)
      ALU_ADD: alu_out = i_op1 + i_op2;
      ALU_SUB: alu_out = i_op1 - i_op2;
      ALU_AND: alu_out = i_op1 & i_op2;
      ALU_OR:  alu_out = i_op1 | i_op2;
      ALU_XOR: alu_out = i_op1 ^ i_op2;
      ALU_SLL: alu_out = i_op1 << i_op2[4:0];
      ALU_SRL: alu_out = i_op1 >> i_op2[4:0];
      ALU_SLT: alu_out = ($signed(i_op1) < $signed(i_op2)) ? 32'd1 : 32'd0;
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      o_done <= 1'b0;
    end else if (i_valid && o_ready) begin
      o_done <= 1'b1;
    end else if (i_grant) begin
      o_done <= 1'b0;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_valid && o_ready) begin
      o_tag    <= i_tag;
      o_result <= alu_out;
    end
  end

endmodule

`default_nettype wire

// File: source/cdb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module cdb_arbiter import ooo_pkg::*; (
  input  wire           clk_100mhz,
  input  wire           sys_rst,
  input  wire           i_alu_done,
  input  wire rob_tag_t i_alu_tag,
  input  wire word_t    i_alu_result,
  input  wire           i_mul_done,
  input  wire rob_tag_t i_mul_tag,
  input  wire word_t    i_mul_result,
  output logic          o_alu_grant,
  output logic          o_mul_grant,
  output logic          o_cdb_valid,
  output rob_tag_t      o_cdb_tag,
  output word_t         o_cdb_value
);

  // fixed priority, alu first
  assign o_alu_grant = i_alu_done;
  assign o_mul_grant = i_mul_done && !i_alu_done;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      o_cdb_valid <= 1'b0;
    end else begin
      o_cdb_valid <= i_alu_done || i_mul_done; // strobe for one cycle
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (o_alu_grant) begin
      o_cdb_tag   <= i_alu_tag;
      o_cdb_value <= i_alu_result;
    end else if (o_mul_grant) begin
      o_cdb_tag   <= i_mul_tag;
      o_cdb_value <= i_mul_result;
    end
  end

endmodule

`default_nettype wire

// File: source/exec_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module exec_core_top import ooo_pkg::*; #(
  parameter int MUL_STAGES = 3
) (
  input  wire            clk_100mhz,
  input  wire            sys_rst,
  input  wire            i_issue_valid,
  input  wire            i_issue_is_mul,
  input  wire alu_func_t i_issue_func,
  input  wire reg_addr_t i_issue_rs1,
  input  wire reg_addr_t i_issue_rs2,
  input  wire            i_issue_use_imm,
  input  wire word_t     i_issue_imm,
  input  wire reg_addr_t i_issue_rd,
  output logic           o_issue_ready,
  output logic           o_commit_valid,
  output reg_addr_t      o_commit_rd,
  output word_t          o_commit_value,
  output rob_tag_t       o_commit_tag
);

  logic      issue_fire;
  logic      rob_full;
  rob_tag_t  alloc_tag;
  rob_tag_t  rob_rd_tag1, rob_rd_tag2;
  logic      rob_rd_done1, rob_rd_done2;
  word_t     rob_rd_val1, rob_rd_val2;
  word_t     op1_val, op2_val;
  logic      op1_ready, op2_ready;
  rob_tag_t  op1_tag, op2_tag;
  logic      cdb_valid;
  rob_tag_t  cdb_tag;
  word_t     cdb_value;

  logic      alu_rs_free, alu_dispatch, alu_ready, alu_done, alu_grant;
  alu_func_t alu_func;
  rob_tag_t  alu_in_tag, alu_out_tag;
  word_t     alu_op1, alu_op2, alu_result;
  logic      mul_rs_free, mul_dispatch, mul_ready, mul_done, mul_grant;
  rob_tag_t  mul_in_tag, mul_out_tag;
  word_t     mul_op1, mul_op2, mul_result;

  // ready needs a rob slot and a free station for the selected unit
  assign o_issue_ready = !rob_full && (i_issue_is_mul ? mul_rs_free : alu_rs_free);
  assign issue_fire    = i_issue_valid && o_issue_ready;

  reorder_buffer u_reorder_buffer (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_alloc(issue_fire), .i_alloc_rd(i_issue_rd),
    .i_cdb_valid(cdb_valid), .i_cdb_tag(cdb_tag), .i_cdb_value(cdb_value),
    .i_rd_tag1(rob_rd_tag1), .i_rd_tag2(rob_rd_tag2),
    .o_alloc_tag(alloc_tag), .o_full(rob_full),
    .o_rd_done1(rob_rd_done1), .o_rd_val1(rob_rd_val1),
    .o_rd_done2(rob_rd_done2), .o_rd_val2(rob_rd_val2),
    .o_commit_valid(o_commit_valid), .o_commit_rd(o_commit_rd),
    .o_commit_value(o_commit_value), .o_commit_tag(o_commit_tag)
  );

  rename_regfile u_rename_regfile (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_rs1(i_issue_rs1), .i_rs2(i_issue_rs2),
    .i_use_imm(i_issue_use_imm), .i_imm(i_issue_imm),
    .i_issue(issue_fire), .i_rd(i_issue_rd), .i_issue_tag(alloc_tag),
    .i_rob_rd_done1(rob_rd_done1), .i_rob_rd_val1(rob_rd_val1),
    .i_rob_rd_done2(rob_rd_done2), .i_rob_rd_val2(rob_rd_val2),
    .i_cdb_valid(cdb_valid), .i_cdb_tag(cdb_tag), .i_cdb_value(cdb_value),
    .i_commit_valid(o_commit_valid), .i_commit_rd(o_commit_rd),
    .i_commit_value(o_commit_value), .i_commit_tag(o_commit_tag),
    .o_rob_rd_tag1(rob_rd_tag1), .o_rob_rd_tag2(rob_rd_tag2),
    .o_op1_val(op1_val), .o_op1_ready(op1_ready), .o_op1_tag(op1_tag),
    .o_op2_val(op2_val), .o_op2_ready(op2_ready), .o_op2_tag(op2_tag)
  );

  reservation_station u_rs_alu (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_load(issue_fire && !i_issue_is_mul), .i_func(i_issue_func), .i_tag(alloc_tag),
    .i_op1_val(op1_val), .i_op1_ready(op1_ready), .i_op1_tag(op1_tag),
    .i_op2_val(op2_val), .i_op2_ready(op2_ready), .i_op2_tag(op2_tag),
    .i_fu_ready(alu_ready),
    .i_cdb_valid(cdb_valid), .i_cdb_tag(cdb_tag), .i_cdb_value(cdb_value),
    .o_free(alu_rs_free), .o_dispatch(alu_dispatch), .o_func(alu_func),
    .o_tag(alu_in_tag), .o_op1(alu_op1), .o_op2(alu_op2)
  );

  reservation_station u_rs_mul (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_load(issue_fire && i_issue_is_mul), .i_func(i_issue_func), .i_tag(alloc_tag),
    .i_op1_val(op1_val), .i_op1_ready(op1_ready), .i_op1_tag(op1_tag),
    .i_op2_val(op2_val), .i_op2_ready(op2_ready), .i_op2_tag(op2_tag),
    .i_fu_ready(mul_ready),
    .i_cdb_valid(cdb_valid), .i_cdb_tag(cdb_tag), .i_cdb_value(cdb_value),
    .o_free(mul_rs_free), .o_dispatch(mul_dispatch), .o_func(), // multiply has no function
    .o_tag(mul_in_tag), .o_op1(mul_op1), .o_op2(mul_op2)
  );

  alu u_alu (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_valid(alu_dispatch), .i_func(alu_func), .i_tag(alu_in_tag),
    .i_op1(alu_op1), .i_op2(alu_op2), .i_grant(alu_grant),
    .o_ready(alu_ready), .o_done(alu_done), .o_tag(alu_out_tag), .o_result(alu_result)
  );

  multiplier #(
    .MUL_STAGES(MUL_STAGES)
  ) u_multiplier (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_valid(mul_dispatch), .i_tag(mul_in_tag),
    .i_op1(mul_op1), .i_op2(mul_op2), .i_grant(mul_grant),
    .o_ready(mul_ready), .o_done(mul_done), .o_tag(mul_out_tag), .o_result(mul_result)
  );

  cdb_arbiter u_cdb_arbiter (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_alu_done(alu_done), .i_alu_tag(alu_out_tag), .i_alu_result(alu_result),
    .i_mul_done(mul_done), .i_mul_tag(mul_out_tag), .i_mul_result(mul_result),
    .o_alu_grant(alu_grant), .o_mul_grant(mul_grant),
    .o_cdb_valid(cdb_valid), .o_cdb_tag(cdb_tag), .o_cdb_value(cdb_value)
  );

endmodule

`default_nettype wire

// File: source/multiplier.sv
`timescale 1ns/100ps
`default_nettype none

module multiplier import ooo_pkg::*; #(
  parameter int MUL_STAGES = 3
) (
  input  wire           clk_100mhz,
  input  wire           sys_rst,
  input  wire           i_valid,
  input  wire rob_tag_t i_tag,
  input  wire word_t    i_op1,
  input  wire word_t    i_op2,
  input  wire           i_grant,
  output logic          o_ready,
  output logic          o_done,
  output rob_tag_t      o_tag,
  output word_t         o_result
);

  logic [MUL_STAGES-1:0] stg_valid;
  rob_tag_t              stg_tag  [MUL_STAGES];
  word_t                 stg_prod [MUL_STAGES];
  logic                  advance;

  // whole pipe stalls while the last stage waits for the bus
  assign advance  = !stg_valid[MUL_STAGES-1] || i_grant;
  assign o_ready  = advance;
  assign o_done   = stg_valid[MUL_STAGES-1];
  assign o_tag    = stg_tag[MUL_STAGES-1];
  assign o_result = stg_prod[MUL_STAGES-1];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      stg_valid <= '0;
    end else if (advance) begin
      stg_valid[0] <= i_valid;
      for (int s = 1; s < MUL_STAGES; s++) begin
        stg_valid[s] <= stg_valid[s-1];
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (advance) begin
      stg_tag[0]  <= i_tag;
      stg_prod[0] <= i_op1 * i_op2; // low 32 bits kept
      for (int s = 1; s < MUL_STAGES; s++) begin
        stg_tag[s]  <= stg_tag[s-1];
        stg_prod[s] <= stg_prod[s-1];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/rename_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module rename_regfile import ooo_pkg::*; (
  input  wire            clk_100mhz,
  input  wire            sys_rst,
  input  wire reg_addr_t i_rs1,
  input  wire reg_addr_t i_rs2,
  input  wire            i_use_imm,
  input  wire word_t     i_imm,
  input  wire            i_issue,
  input  wire reg_addr_t i_rd,
  input  wire rob_tag_t  i_issue_tag,
  input  wire            i_rob_rd_done1,
  input  wire word_t     i_rob_rd_val1,
  input  wire            i_rob_rd_done2,
  input  wire word_t     i_rob_rd_val2,
  input  wire            i_cdb_valid,
  input  wire rob_tag_t  i_cdb_tag,
  input  wire word_t     i_cdb_value,
  input  wire            i_commit_valid,
  input  wire reg_addr_t i_commit_rd,
  input  wire word_t     i_commit_value,
  input  wire rob_tag_t  i_commit_tag,
  output rob_tag_t       o_rob_rd_tag1,
  output rob_tag_t       o_rob_rd_tag2,
  output word_t          o_op1_val,
  output logic           o_op1_ready,
  output rob_tag_t       o_op1_tag,
  output word_t          o_op2_val,
  output logic           o_op2_ready,
  output rob_tag_t       o_op2_tag
);

  word_t               regs [NUM_REGS];
  rob_tag_t            tags [NUM_REGS];
  logic [NUM_REGS-1:0] busy;

  assign o_rob_rd_tag1 = tags[i_rs1];
  assign o_rob_rd_tag2 = tags[i_rs2];
  assign o_op1_tag     = tags[i_rs1];
  assign o_op2_tag     = tags[i_rs2];

  // regfile, then done rob entry, then live bus, else wait on tag
  always_comb begin
    o_op1_val   = regs[i_rs1];
    o_op1_ready = 1'b1;
    if (busy[i_rs1]) begin
      if (i_rob_rd_done1) begin
        o_op1_val = i_rob_rd_val1;
      end else if (i_cdb_valid && (i_cdb_tag == tags[i_rs1])) begin
        o_op1_val = i_cdb_value;
      end else begin
        o_op1_ready = 1'b0;
      end
    end
    o_op2_val   = regs[i_rs2];
    o_op2_ready = 1'b1;
    if (i_use_imm) begin
      o_op2_val = i_imm; // immediate replaces rs2
    end else if (busy[i_rs2]) begin
      if (i_rob_rd_done2) begin
        o_op2_val = i_rob_rd_val2;
      end else if (i_cdb_valid && (i_cdb_tag == tags[i_rs2])) begin
        o_op2_val = i_cdb_value;
      end else begin
        o_op2_ready = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy <= '0;
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      if (i_commit_valid) begin
        regs[i_commit_rd] <= i_commit_value;
        if (tags[i_commit_rd] == i_commit_tag) begin
          busy[i_commit_rd] <= 1'b0; // only if not renamed since
        end
      end
      if (i_issue) begin
        busy[i_rd] <= 1'b1; // a rename wins over a same-cycle commit
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_issue) begin
      tags[i_rd] <= i_issue_tag;
    end
  end

endmodule

`default_nettype wire

// File: source/reservation_station.sv
`timescale 1ns/100ps
`default_nettype none

module reservation_station import ooo_pkg::*; (
  input  wire            clk_100mhz,
  input  wire            sys_rst,
  input  wire            i_load,
  input  wire alu_func_t i_func,
  input  wire rob_tag_t  i_tag,
  input  wire word_t     i_op1_val,
  input  wire            i_op1_ready,
  input  wire rob_tag_t  i_op1_tag,
  input  wire word_t     i_op2_val,
  input  wire            i_op2_ready,
  input  wire rob_tag_t  i_op2_tag,
  input  wire            i_fu_ready,
  input  wire            i_cdb_valid,
  input  wire rob_tag_t  i_cdb_tag,
  input  wire word_t     i_cdb_value,
  output logic           o_free,
  output logic           o_dispatch,
  output alu_func_t      o_func,
  output rob_tag_t       o_tag,
  output word_t          o_op1,
  output word_t          o_op2
);

  logic     busy;
  logic     op1_rdy;
  logic     op2_rdy;
  rob_tag_t op1_tag;
  rob_tag_t op2_tag;
  logic     op1_hit;
  logic     op2_hit;

  // waiting operand whose producer is on the bus now
  assign op1_hit = busy && !op1_rdy && i_cdb_valid && (i_cdb_tag == op1_tag);
  assign op2_hit = busy && !op2_rdy && i_cdb_valid && (i_cdb_tag == op2_tag);

  assign o_free     = !busy;
  assign o_dispatch = busy && op1_rdy && op2_rdy && i_fu_ready;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy    <= 1'b0;
      op1_rdy <= 1'b0;
      op2_rdy <= 1'b0;
    end else if (i_load) begin
      busy    <= 1'b1;
      op1_rdy <= i_op1_ready;
      op2_rdy <= i_op2_ready;
    end else begin
      if (o_dispatch) begin
        busy <= 1'b0; // entry leaves for the unit
      end
      if (op1_hit) begin
        op1_rdy <= 1'b1;
      end
      if (op2_hit) begin
        op2_rdy <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_load) begin
      o_func  <= i_func;
      o_tag   <= i_tag;
      o_op1   <= i_op1_val;
      o_op2   <= i_op2_val;
      op1_tag <= i_op1_tag;
      op2_tag <= i_op2_tag;
    end else begin
      if (op1_hit) begin
        o_op1 <= i_cdb_value;
      end
      if (op2_hit) begin
        o_op2 <= i_cdb_value;
      end
    end
  end

endmodule

`default_nettype wire
